//--- control_unit.sv
/*
 * Combinational instruction decoder. Produces register indexes,
 * immediates, ALU and write-back selects and memory byte enables.
 */
`timescale 1ns/1ns
`default_nettype none

module control_unit (
  input  logic [31:0]          instr_i,
  input  logic [1:0]           byte_offset_i,
  output logic [4:0]           rs1_o,
  output logic [4:0]           rs2_o,
  output logic [4:0]           rd_o,
  output logic [31:0]          imm_i_o,
  output logic [31:0]          imm_s_o,
  output logic [31:0]          imm_b_o,
  output logic [31:0]          imm_j_o,
  output logic [31:0]          imm_u_o,
  output rv32i_pkg::alu_op_t   alu_op_o,
  output logic [1:0]           alu_a_sel_o,
  output logic [1:0]           alu_b_sel_o,
  output rv32i_pkg::w_sel_t    w_sel_o,
  output logic                 wen_o,
  output logic                 dren_o,
  output logic                 dwen_o,
  output logic                 branch_o,
  output logic                 jump_o,
  output logic                 j_sel_o,
  output logic                 halt_o,
  output rv32i_pkg::load_t     load_type_o,
  output rv32i_pkg::branch_t   branch_type_o,
  output logic [3:0]           byte_en_o
);

  rv32i_pkg::opcode_t opcode;
  logic [2:0]         funct3;
  logic               alt;

  assign opcode = rv32i_pkg::opcode_t'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  // Bit 30 selects SUB and SRA/SRAI
  assign alt    = instr_i[30];

  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];
  assign rd_o  = instr_i[11:7];

  assign imm_i_o = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
  assign imm_j_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
  assign imm_u_o = {instr_i[31:12], 12'b0};

  assign load_type_o   = rv32i_pkg::load_t'(funct3);
  assign branch_type_o = rv32i_pkg::branch_t'(funct3);

  assign dren_o   = (opcode == rv32i_pkg::LOAD);
  assign dwen_o   = (opcode == rv32i_pkg::STORE);
  assign branch_o = (opcode == rv32i_pkg::BRANCH);
  assign jump_o   = (opcode == rv32i_pkg::JAL) || (opcode == rv32i_pkg::JALR);
  assign j_sel_o  = (opcode == rv32i_pkg::JAL);
  assign halt_o   = (instr_i == rv32i_pkg::HALT_INSTR);

  // Enables, operand and write-back selects per opcode
  always_comb begin
    wen_o       = 1'b0;
    alu_a_sel_o = 2'd0;
    alu_b_sel_o = 2'd0;
    w_sel_o     = rv32i_pkg::WB_ALU;
    case (opcode)
      rv32i_pkg::LUI: begin
        wen_o       = 1'b1;
        alu_a_sel_o = 2'd2;
        w_sel_o     = rv32i_pkg::WB_IMM_U;
      end
      rv32i_pkg::AUIPC: begin
        wen_o       = 1'b1;
        alu_a_sel_o = 2'd1;
        alu_b_sel_o = 2'd3;
      end
      rv32i_pkg::JAL, rv32i_pkg::JALR: begin
        wen_o   = 1'b1;
        w_sel_o = rv32i_pkg::WB_LINK;
      end
      rv32i_pkg::BRANCH: alu_b_sel_o = 2'd1;
      rv32i_pkg::LOAD: begin
        wen_o   = 1'b1;
        w_sel_o = rv32i_pkg::WB_LOAD;
      end
      rv32i_pkg::STORE:  alu_b_sel_o = 2'd2;
      rv32i_pkg::IMMED:  wen_o = 1'b1;
      rv32i_pkg::REGREG: begin
        wen_o       = 1'b1;
        alu_b_sel_o = 2'd1;
      end
      default: wen_o = 1'b0;
    endcase
  end

  // Address and link arithmetic use the default add
  always_comb begin
    alu_op_o = rv32i_pkg::ALU_ADD;
    if (opcode == rv32i_pkg::IMMED || opcode == rv32i_pkg::REGREG) begin
      case (funct3)
        rv32i_pkg::ADDSUB: alu_op_o = (opcode == rv32i_pkg::REGREG && alt) ?
                                      rv32i_pkg::ALU_SUB : rv32i_pkg::ALU_ADD;
        rv32i_pkg::SLL:    alu_op_o = rv32i_pkg::ALU_SLL;
        rv32i_pkg::SLT:    alu_op_o = rv32i_pkg::ALU_SLT;
        rv32i_pkg::SLTU:   alu_op_o = rv32i_pkg::ALU_SLTU;
        rv32i_pkg::XOR:    alu_op_o = rv32i_pkg::ALU_XOR;
        rv32i_pkg::SR:     alu_op_o = alt ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
        rv32i_pkg::OR:     alu_op_o = rv32i_pkg::ALU_OR;
        default:           alu_op_o = rv32i_pkg::ALU_AND;
      endcase
    end
  end

  // Misaligned halves and words get no lanes at all
  always_comb begin
    case (load_type_o)
      rv32i_pkg::LB, rv32i_pkg::LBU: byte_en_o = 4'b0001 << byte_offset_i;
      rv32i_pkg::LH, rv32i_pkg::LHU: begin
        case (byte_offset_i)
          2'b00:   byte_en_o = 4'b0011;
          2'b10:   byte_en_o = 4'b1100;
          default: byte_en_o = 4'b0000;
        endcase
      end
      rv32i_pkg::LW: byte_en_o = (byte_offset_i == 2'b00) ? 4'b1111 : 4'b0000;
      default:       byte_en_o = 4'b0000;
    endcase
  end

endmodule

`default_nettype wire

//--- execute_unit.sv
/*
 * Execute stage. Picks the ALU operands, runs the ALU, resolves
 * branches and jumps and produces the next program counter.
 */
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
  input  logic [31:0]        pc_i,
  input  logic [31:0]        rdata1_i,
  input  logic [31:0]        rdata2_i,
  input  logic [31:0]        imm_i_i,
  input  logic [31:0]        imm_s_i,
  input  logic [31:0]        imm_b_i,
  input  logic [31:0]        imm_j_i,
  input  logic [31:0]        imm_u_i,
  input  rv32i_pkg::alu_op_t alu_op_i,
  input  logic [1:0]         alu_a_sel_i,
  input  logic [1:0]         alu_b_sel_i,
  input  logic               branch_i,
  input  logic               jump_i,
  input  logic               j_sel_i,
  input  rv32i_pkg::branch_t branch_type_i,
  output logic [31:0]        alu_result_o,
  output logic [31:0]        next_pc_o,
  output logic [31:0]        link_o
);

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] pc_plus4;
  logic        taken;

  assign pc_plus4 = pc_i + 32'd4;
  assign link_o   = pc_plus4;

  always_comb begin
    case (alu_a_sel_i)
      2'd1:    op_a = pc_i;
      2'd2:    op_a = imm_u_i;
      default: op_a = rdata1_i;
    endcase
    case (alu_b_sel_i)
      2'd1:    op_b = rdata2_i;
      2'd2:    op_b = imm_s_i;
      2'd3:    op_b = imm_u_i;
      default: op_b = imm_i_i;
    endcase
  end

  always_comb begin
    case (alu_op_i)
      rv32i_pkg::ALU_SUB:  alu_result_o = op_a - op_b;
      rv32i_pkg::ALU_SLL:  alu_result_o = op_a << op_b[4:0];
      rv32i_pkg::ALU_SRL:  alu_result_o = op_a >> op_b[4:0];
      rv32i_pkg::ALU_SRA:  alu_result_o = $signed(op_a) >>> op_b[4:0];
      rv32i_pkg::ALU_AND:  alu_result_o = op_a & op_b;
      rv32i_pkg::ALU_OR:   alu_result_o = op_a | op_b;
      rv32i_pkg::ALU_XOR:  alu_result_o = op_a ^ op_b;
      rv32i_pkg::ALU_SLT:  alu_result_o = {31'd0, $signed(op_a) < $signed(op_b)};
      rv32i_pkg::ALU_SLTU: alu_result_o = {31'd0, op_a < op_b};
      default:             alu_result_o = op_a + op_b;
    endcase
  end

  // Branch compare works on the raw register values
  always_comb begin
    case (branch_type_i)
      rv32i_pkg::BEQ:  taken = (rdata1_i == rdata2_i);
      rv32i_pkg::BNE:  taken = (rdata1_i != rdata2_i);
      rv32i_pkg::BLT:  taken = ($signed(rdata1_i) < $signed(rdata2_i));
      rv32i_pkg::BGE:  taken = ($signed(rdata1_i) >= $signed(rdata2_i));
      rv32i_pkg::BLTU: taken = (rdata1_i < rdata2_i);
      rv32i_pkg::BGEU: taken = (rdata1_i >= rdata2_i);
      default:         taken = 1'b0;
    endcase
  end

  always_comb begin
    if (jump_i && j_sel_i) begin
      next_pc_o = pc_i + imm_j_i;
    end else if (jump_i) begin
      // JALR target is rs1 + imm with bit 0 dropped
      next_pc_o = {alu_result_o[31:1], 1'b0};
    end else if (branch_i && taken) begin
      next_pc_o = pc_i + imm_b_i;
    end else begin
      next_pc_o = pc_plus4;
    end
  end

endmodule

`default_nettype wire

//--- mem_access.sv
/*
 * Data port driver and write-back mux. Places store data on the lanes,
 * extracts and extends load data, then picks the register write value.
 */
`timescale 1ns/1ns
`default_nettype none

module mem_access (
  input  logic [31:0]        alu_result_i,
  input  logic [31:0]        rdata2_i,
  input  logic [31:0]        link_i,
  input  logic [31:0]        imm_u_i,
  input  rv32i_pkg::w_sel_t  w_sel_i,
  input  rv32i_pkg::load_t   load_type_i,
  input  logic [3:0]         byte_en_i,
  input  logic               dren_i,
  input  logic               dwen_i,
  input  logic               wen_i,
  input  logic               active_i,
  input  logic [31:0]        dmem_rdata_i,
  output logic [31:0]        dmem_addr_o,
  output logic [31:0]        dmem_wdata_o,
  output logic [3:0]         dmem_byte_en_o,
  output logic               dmem_wen_o,
  output logic               dmem_ren_o,
  output logic [31:0]        wb_data_o,
  output logic               wb_en_o
);

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;
  logic [31:0] load_data;

  assign dmem_addr_o    = {alu_result_i[31:2], 2'b00};
  assign dmem_byte_en_o = byte_en_i;
  // A misaligned access leaves no lanes and so raises no strobe
  assign dmem_wen_o     = dwen_i && active_i && (byte_en_i != 4'b0000);
  assign dmem_ren_o     = dren_i && active_i && (byte_en_i != 4'b0000);
  assign wb_en_o        = wen_i && active_i;

  always_comb begin
    case (load_type_i)
      rv32i_pkg::LB: dmem_wdata_o = {4{rdata2_i[7:0]}};
      rv32i_pkg::LH: dmem_wdata_o = {2{rdata2_i[15:0]}};
      default:       dmem_wdata_o = rdata2_i;
    endcase
  end

  assign lane_byte = dmem_rdata_i[{alu_result_i[1:0], 3'b000} +: 8];
  assign lane_half = dmem_rdata_i[{alu_result_i[1], 4'b0000} +: 16];

  always_comb begin
    case (load_type_i)
      rv32i_pkg::LB:  load_data = {{24{lane_byte[7]}}, lane_byte};
      rv32i_pkg::LH:  load_data = {{16{lane_half[15]}}, lane_half};
      rv32i_pkg::LBU: load_data = {24'd0, lane_byte};
      rv32i_pkg::LHU: load_data = {16'd0, lane_half};
      default:        load_data = dmem_rdata_i;
    endcase
  end

  always_comb begin
    case (w_sel_i)
      rv32i_pkg::WB_LOAD:  wb_data_o = load_data;
      rv32i_pkg::WB_LINK:  wb_data_o = link_i;
      rv32i_pkg::WB_IMM_U: wb_data_o = imm_u_i;
      default:             wb_data_o = alu_result_i;
    endcase
  end

endmodule

`default_nettype wire

//--- reg_file.sv
/*
 * Integer register file, two asynchronous reads and one clocked write.
 * Entry 0 is never written.
 */
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
  parameter int REG_COUNT = 32
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic [4:0]  rs1_i,
  input  logic [4:0]  rs2_i,
  input  logic [4:0]  rd_i,
  input  logic        wen_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata1_o,
  output logic [31:0] rdata2_o
);

  localparam int AW = $clog2(REG_COUNT);

  logic [31:0] regs [REG_COUNT];

  // Upper index bits are ignored in the 16-entry variant
  assign rdata1_o = regs[rs1_i[AW-1:0]];
  assign rdata2_o = regs[rs2_i[AW-1:0]];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (rd_i[AW-1:0] != '0)) begin
      regs[rd_i[AW-1:0]] <= wdata_i;
    end
  end

  x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
    (rs1_i == 5'd0) |-> (rdata1_o == 32'd0));

  x0_reads_zero_b: assert property (@(posedge clk) disable iff (!rst_n_i)
    (rs2_i == 5'd0) |-> (rdata2_o == 32'd0));

endmodule

`default_nettype wire

//--- rv32i_core.f
rv32i_pkg.sv
control_unit.sv
reg_file.sv
execute_unit.sv
mem_access.sv
rv32i_core.sv
tb_rv32i_core.sv

//--- rv32i_core.sv
/*
 * Single-cycle RV32I core. Holds the PC and halt flag and wires the
 * decoder, register file, execute stage and memory stage together.
 */
`timescale 1ns/1ns
`default_nettype none

module rv32i_core #(
  parameter logic [31:0] RESET_PC  = 32'd0,
  parameter int          REG_COUNT = 32
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        run_i,
  input  logic [31:0] imem_rdata_i,
  input  logic [31:0] dmem_rdata_i,
  output logic [31:0] imem_addr_o,
  output logic [31:0] dmem_addr_o,
  output logic [31:0] dmem_wdata_o,
  output logic [3:0]  dmem_byte_en_o,
  output logic        dmem_wen_o,
  output logic        dmem_ren_o,
  output logic        rd_wen_o,
  output logic [4:0]  rd_addr_o,
  output logic [31:0] rd_wdata_o,
  output logic        halt_o
);

  logic [31:0] pc_q;
  logic        halt_q;
  logic        active;

  logic [4:0]  rs1, rs2, rd;
  logic [31:0] imm_i, imm_s, imm_b, imm_j, imm_u;
  logic [1:0]  alu_a_sel, alu_b_sel;
  logic        wen, dren, dwen, branch, jump, j_sel, halt_instr;
  logic [3:0]  byte_en;
  logic [31:0] rdata1, rdata2, alu_result, next_pc, link, wb_data;
  logic        wb_en;

  rv32i_pkg::alu_op_t   alu_op;
  rv32i_pkg::w_sel_t    w_sel;
  rv32i_pkg::load_t     load_type;
  rv32i_pkg::branch_t   branch_type;

  assign active      = run_i && !halt_q;
  assign imem_addr_o = pc_q;
  assign halt_o      = halt_q;

  // The halt word stops the PC on itself
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q   <= RESET_PC;
      halt_q <= 1'b0;
    end else if (active) begin
      if (halt_instr) begin
        halt_q <= 1'b1;
      end else begin
        pc_q <= next_pc;
      end
    end
  end

  control_unit i_control_unit (
    .instr_i(imem_rdata_i), .byte_offset_i(alu_result[1:0]),
    .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd),
    .imm_i_o(imm_i), .imm_s_o(imm_s), .imm_b_o(imm_b), .imm_j_o(imm_j), .imm_u_o(imm_u),
    .alu_op_o(alu_op), .alu_a_sel_o(alu_a_sel), .alu_b_sel_o(alu_b_sel), .w_sel_o(w_sel),
    .wen_o(wen), .dren_o(dren), .dwen_o(dwen), .branch_o(branch), .jump_o(jump),
    .j_sel_o(j_sel), .halt_o(halt_instr), .load_type_o(load_type),
    .branch_type_o(branch_type), .byte_en_o(byte_en)
  );

  reg_file #(.REG_COUNT(REG_COUNT)) i_reg_file (
    .clk(clk), .rst_n_i(rst_n_i), .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd),
    .wen_i(wb_en), .wdata_i(wb_data), .rdata1_o(rdata1), .rdata2_o(rdata2)
  );

  execute_unit i_execute_unit (
    .pc_i(pc_q), .rdata1_i(rdata1), .rdata2_i(rdata2),
    .imm_i_i(imm_i), .imm_s_i(imm_s), .imm_b_i(imm_b), .imm_j_i(imm_j), .imm_u_i(imm_u),
    .alu_op_i(alu_op), .alu_a_sel_i(alu_a_sel), .alu_b_sel_i(alu_b_sel),
    .branch_i(branch), .jump_i(jump), .j_sel_i(j_sel), .branch_type_i(branch_type),
    .alu_result_o(alu_result), .next_pc_o(next_pc), .link_o(link)
  );

  mem_access i_mem_access (
    .alu_result_i(alu_result), .rdata2_i(rdata2), .link_i(link), .imm_u_i(imm_u),
    .w_sel_i(w_sel), .load_type_i(load_type), .byte_en_i(byte_en),
    .dren_i(dren), .dwen_i(dwen), .wen_i(wen), .active_i(active),
    .dmem_rdata_i(dmem_rdata_i), .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
    .dmem_byte_en_o(dmem_byte_en_o), .dmem_wen_o(dmem_wen_o), .dmem_ren_o(dmem_ren_o),
    .wb_data_o(wb_data), .wb_en_o(wb_en)
  );

  // Retire port only shows writes that land in a real register
  assign rd_wen_o   = wb_en && (rd != 5'd0);
  assign rd_addr_o  = rd;
  assign rd_wdata_o = wb_data;

endmodule

`default_nettype wire

//--- rv32i_pkg.sv
/*
 * Shared encodings for the single-cycle RV32I core.
 * Modules refer to these by scoped name.
 */
`default_nettype none

package rv32i_pkg;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011,
    SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // Stores reuse the LB, LH and LW codes
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // Funct3 of the immediate and register ALU groups
  localparam logic [2:0] ADDSUB = 3'b000;
  localparam logic [2:0] ADDI   = 3'b000;
  localparam logic [2:0] SLL    = 3'b001;
  localparam logic [2:0] SLLI   = 3'b001;
  localparam logic [2:0] SLT    = 3'b010;
  localparam logic [2:0] SLTU   = 3'b011;
  localparam logic [2:0] XOR    = 3'b100;
  localparam logic [2:0] SR     = 3'b101;
  localparam logic [2:0] SRI    = 3'b101;
  localparam logic [2:0] OR     = 3'b110;
  localparam logic [2:0] AND    = 3'b111;

  // Write-back source
  typedef enum logic [1:0] {
    WB_LOAD  = 2'd0,
    WB_LINK  = 2'd1,
    WB_IMM_U = 2'd2,
    WB_ALU   = 2'd3
  } w_sel_t;

  // Fixed word that stops the core
  localparam logic [31:0] HALT_INSTR = 32'h7800d073;

endpackage

`default_nettype wire

//--- tb_rv32i_core.sv
/*
 * Directed testbench for the single-cycle RV32I core. Holds the instruction
 * and data memories, builds small programs and checks every retire and access.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_rv32i_core;

  // About twice the cycles that all five tests need
  localparam int MAX_CYCLES = 400;

  logic        clk = 1'b0;
  logic        rst_n_i = 1'b0;
  logic        run_i = 1'b0;
  logic [31:0] imem_rdata_i;
  logic [31:0] dmem_rdata_i;
  logic [31:0] imem_addr_o;
  logic [31:0] dmem_addr_o;
  logic [31:0] dmem_wdata_o;
  logic [3:0]  dmem_byte_en_o;
  logic        dmem_wen_o;
  logic        dmem_ren_o;
  logic        rd_wen_o;
  logic [4:0]  rd_addr_o;
  logic [31:0] rd_wdata_o;
  logic        halt_o;

  logic [31:0] imem [64];
  logic [31:0] dmem [64];
  logic [31:0] ref_regs [32];
  logic [31:0] lcg_state = 32'hcaac_0b35;
  int          cursor;
  int          cycle_count = 0;

  // Expected path, retires, stores and loads in program order
  logic [31:0] exp_pc [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_val [$];
  logic [31:0] st_addr [$];
  logic [3:0]  st_be [$];
  logic [31:0] st_data [$];
  logic [31:0] ld_addr [$];
  logic [3:0]  ld_be [$];

  rv32i_core i_rv32i_core (
    .clk(clk), .rst_n_i(rst_n_i), .run_i(run_i),
    .imem_rdata_i(imem_rdata_i), .dmem_rdata_i(dmem_rdata_i), .imem_addr_o(imem_addr_o),
    .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o), .dmem_byte_en_o(dmem_byte_en_o),
    .dmem_wen_o(dmem_wen_o), .dmem_ren_o(dmem_ren_o), .rd_wen_o(rd_wen_o),
    .rd_addr_o(rd_addr_o), .rd_wdata_o(rd_wdata_o), .halt_o(halt_o)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  // Both memories answer in the same cycle
  assign imem_rdata_i = imem[imem_addr_o[7:2]];
  assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];

  always @(posedge clk) begin
    if (dmem_wen_o) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_byte_en_o[b]) begin
          dmem[dmem_addr_o[7:2]][8*b +: 8] <= dmem_wdata_o[8*b +: 8];
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      report_failure($sformatf("timeout, tests still running after %0d cycles", MAX_CYCLES));
    end
  end

  task automatic stop_with_failure();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_failure(string msg);
    $display("%s", msg);
    stop_with_failure();
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv32i_pkg::REGREG};
  endfunction

  function automatic logic [31:0] i_type(rv32i_pkg::opcode_t op, logic [4:0] rd,
                                         logic [2:0] f3, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv32i_pkg::STORE};
  endfunction

  function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv32i_pkg::BRANCH};
  endfunction

  function automatic logic [31:0] u_type(rv32i_pkg::opcode_t op, logic [4:0] rd,
                                         logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv32i_pkg::JAL};
  endfunction

  // RV32I integer semantics for the ALU groups
  function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
    logic [31:0] r;
    case (f3)
      rv32i_pkg::ADDSUB: r = alt ? a - b : a + b;
      rv32i_pkg::SLL:    r = a << b[4:0];
      rv32i_pkg::SLT:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv32i_pkg::SLTU:   r = (a < b) ? 32'd1 : 32'd0;
      rv32i_pkg::XOR:    r = a ^ b;
      rv32i_pkg::SR: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      rv32i_pkg::OR:     r = a | b;
      default:           r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_model(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      rv32i_pkg::BEQ:  return a == b;
      rv32i_pkg::BNE:  return a != b;
      rv32i_pkg::BLT:  return $signed(a) < $signed(b);
      rv32i_pkg::BGE:  return $signed(a) >= $signed(b);
      rv32i_pkg::BLTU: return a < b;
      default:         return a >= b;
    endcase
  endfunction

  task automatic clear_program();
    for (int i = 0; i < 64; i++) begin
      imem[i] = rv32i_pkg::HALT_INSTR;
      dmem[i] = {2'b10, i[5:0], 2'b01, i[5:0], 2'b11, i[5:0], 2'b00, i[5:0]};
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = 32'd0;
    end
    exp_pc.delete();
    exp_rd.delete();
    exp_val.delete();
    st_addr.delete();
    st_be.delete();
    st_data.delete();
    ld_addr.delete();
    ld_be.delete();
    cursor = 0;
  endtask

  // Place a word on the executed path
  task automatic emit(logic [31:0] word);
    imem[cursor] = word;
    exp_pc.push_back(cursor * 4);
    cursor++;
  endtask

  // Word that must never run and would retire into x31
  task automatic skip_slot();
    imem[cursor] = i_type(rv32i_pkg::IMMED, 5'd31, rv32i_pkg::ADDI, 5'd0, 12'h7ff);
    cursor++;
  endtask

  task automatic expect_write(logic [4:0] rd, logic [31:0] val);
    if (rd != 5'd0) begin
      ref_regs[rd] = val;
      exp_rd.push_back(rd);
      exp_val.push_back(val);
    end
  endtask

  task automatic expect_store(logic [31:0] addr, logic [3:0] be, logic [31:0] data);
    st_addr.push_back(addr);
    st_be.push_back(be);
    st_data.push_back(data);
  endtask

  task automatic expect_load(logic [31:0] addr, logic [3:0] be);
    ld_addr.push_back(addr);
    ld_be.push_back(be);
  endtask

  task automatic load_const(logic [4:0] rd, logic [31:0] v);
    logic [31:0] upper;
    upper = (v + 32'h800) >> 12;
    emit(u_type(rv32i_pkg::LUI, rd, upper[19:0]));
    expect_write(rd, {upper[19:0], 12'd0});
    emit(i_type(rv32i_pkg::IMMED, rd, rv32i_pkg::ADDI, rd, v[11:0]));
    expect_write(rd, v);
  endtask

  task automatic alu_imm(logic [4:0] rd, logic [4:0] rs1, logic [2:0] f3, logic [11:0] imm);
    logic alt;
    alt = (f3 == rv32i_pkg::SRI) && imm[10];
    emit(i_type(rv32i_pkg::IMMED, rd, f3, rs1, imm));
    expect_write(rd, alu_model(f3, alt, ref_regs[rs1], {{20{imm[11]}}, imm}));
  endtask

  task automatic alu_reg(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2, logic [2:0] f3,
                         logic alt);
    emit(r_type({1'b0, alt, 5'd0}, rs2, rs1, f3, rd));
    expect_write(rd, alu_model(f3, alt, ref_regs[rs1], ref_regs[rs2]));
  endtask

  // Offset 8 jumps over one slot that bumps x10 when it runs
  task automatic branch_over_slot(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2);
    emit(b_type(f3, rs1, rs2, 13'd8));
    if (branch_model(f3, ref_regs[rs1], ref_regs[rs2])) begin
      skip_slot();
    end else begin
      alu_imm(5'd10, 5'd10, rv32i_pkg::ADDI, 12'd1);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n_i <= 1'b0;
    run_i   <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n_i <= 1'b1;
  endtask

  task automatic check_cycle();
    if (exp_pc.size() == 0) begin
      report_failure("core fetched past the end of the expected path");
    end
    check_value("imem_addr_o", imem_addr_o, exp_pc.pop_front());
    if (rd_wen_o) begin
      if (exp_rd.size() == 0) begin
        report_failure("register write retired where none was expected");
      end
      check_value("rd_addr_o", rd_addr_o, exp_rd.pop_front());
      check_value("rd_wdata_o", rd_wdata_o, exp_val.pop_front());
    end
    if (dmem_wen_o) begin
      if (st_addr.size() == 0) begin
        report_failure("data store seen where none was expected");
      end
      check_value("dmem_addr_o", dmem_addr_o, st_addr.pop_front());
      check_value("dmem_byte_en_o", dmem_byte_en_o, st_be.pop_front());
      check_value("dmem_wdata_o", dmem_wdata_o, st_data.pop_front());
    end
    if (dmem_ren_o) begin
      if (ld_addr.size() == 0) begin
        report_failure("data load seen where none was expected");
      end
      check_value("dmem_addr_o", dmem_addr_o, ld_addr.pop_front());
      check_value("dmem_byte_en_o", dmem_byte_en_o, ld_be.pop_front());
    end
  endtask

  // Outputs are sampled on the falling edge halfway between updates
  task automatic run_until_halt();
    @(posedge clk);
    run_i <= 1'b1;
    @(negedge clk);
    while (!halt_o) begin
      check_cycle();
      @(negedge clk);
    end
    if (exp_pc.size() != 0 || exp_rd.size() != 0 || st_addr.size() != 0 ||
        ld_addr.size() != 0) begin
      report_failure("core halted before all expected instructions retired");
    end
  endtask

  task automatic check_frozen(logic [31:0] pc, logic halted);
    repeat (4) begin
      @(negedge clk);
      check_value("imem_addr_o", imem_addr_o, pc);
      check_value("halt_o", halt_o, halted);
      check_value("dmem_wen_o", dmem_wen_o, 1'b0);
      check_value("dmem_ren_o", dmem_ren_o, 1'b0);
      check_value("rd_wen_o", rd_wen_o, 1'b0);
    end
  endtask

  task automatic test_alu();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [4:0]  rd;
    clear_program();
    load_const(5'd1, next_rand() | 32'h8000_0000);
    load_const(5'd2, next_rand());
    rd = 5'd3;
    for (int k = 0; k < 8; k++) begin
      f3 = k[2:0];
      r = next_rand();
      if (f3 == rv32i_pkg::SLLI || f3 == rv32i_pkg::SRI) begin
        alu_imm(rd, 5'd1, f3, {7'h00, r[4:0]});
      end else begin
        alu_imm(rd, 5'd1, f3, r[11:0]);
      end
      rd++;
      if (f3 == rv32i_pkg::SRI) begin
        alu_imm(rd, 5'd1, f3, {7'h20, r[9:5]});
        rd++;
      end
      alu_reg(rd, 5'd1, 5'd2, f3, 1'b0);
      rd++;
      if (f3 == rv32i_pkg::ADDSUB || f3 == rv32i_pkg::SR) begin
        alu_reg(rd, 5'd1, 5'd2, f3, 1'b1);
        rd++;
      end
    end
    emit(rv32i_pkg::HALT_INSTR);
    apply_reset();
    run_until_halt();
  endtask

  task automatic test_load_store();
    logic [31:0] v;
    clear_program();
    v = next_rand() | 32'h8080_8080;
    load_const(5'd5, v);
    load_const(5'd6, 32'h40);
    for (int off = 0; off < 4; off++) begin
      emit(s_type(rv32i_pkg::LB, 5'd6, 5'd5, off));
      expect_store(32'h40, 4'b0001 << off, {4{v[7:0]}});
    end
    emit(s_type(rv32i_pkg::LH, 5'd6, 5'd5, 12'd4));
    expect_store(32'h44, 4'b0011, {2{v[15:0]}});
    emit(s_type(rv32i_pkg::LH, 5'd6, 5'd5, 12'd6));
    expect_store(32'h44, 4'b1100, {2{v[15:0]}});
    emit(s_type(rv32i_pkg::LW, 5'd6, 5'd5, 12'd8));
    expect_store(32'h48, 4'b1111, v);
    // Every byte of v has its top bit set
    for (int off = 0; off < 4; off++) begin
      emit(i_type(rv32i_pkg::LOAD, 5'd7, rv32i_pkg::LB, 5'd6, 8 + off));
      expect_load(32'h48, 4'b0001 << off);
      expect_write(5'd7, {{24{v[8*off+7]}}, v[8*off +: 8]});
      emit(i_type(rv32i_pkg::LOAD, 5'd7, rv32i_pkg::LBU, 5'd6, 8 + off));
      expect_load(32'h48, 4'b0001 << off);
      expect_write(5'd7, {24'd0, v[8*off +: 8]});
    end
    for (int h = 0; h < 2; h++) begin
      emit(i_type(rv32i_pkg::LOAD, 5'd7, rv32i_pkg::LH, 5'd6, 8 + 2 * h));
      expect_load(32'h48, 4'b0011 << (2 * h));
      expect_write(5'd7, {{16{v[16*h+15]}}, v[16*h +: 16]});
      emit(i_type(rv32i_pkg::LOAD, 5'd7, rv32i_pkg::LHU, 5'd6, 8 + 2 * h));
      expect_load(32'h48, 4'b0011 << (2 * h));
      expect_write(5'd7, {16'd0, v[16*h +: 16]});
    end
    emit(i_type(rv32i_pkg::LOAD, 5'd7, rv32i_pkg::LW, 5'd6, 12'd8));
    expect_load(32'h48, 4'b1111);
    expect_write(5'd7, v);
    emit(rv32i_pkg::HALT_INSTR);
    apply_reset();
    run_until_halt();
  endtask

  task automatic test_control_flow();
    logic [2:0] f3;
    int         pc;
    clear_program();
    // x1 negative, x2 positive, x3 a copy of x1
    load_const(5'd1, next_rand() | 32'h8000_0000);
    load_const(5'd2, next_rand() & 32'h7fff_ffff);
    alu_imm(5'd3, 5'd1, rv32i_pkg::ADDI, 12'd0);
    for (int t = 0; t < 8; t++) begin
      f3 = t[2:0];
      if (f3 != 3'b010 && f3 != 3'b011) begin
        branch_over_slot(f3, 5'd1, 5'd2);
        branch_over_slot(f3, 5'd2, 5'd1);
        branch_over_slot(f3, 5'd1, 5'd3);
      end
    end
    pc = cursor * 4;
    emit(j_type(5'd11, 21'd12));
    expect_write(5'd11, pc + 4);
    skip_slot();
    skip_slot();
    // Odd sum checks that JALR drops bit 0
    pc = cursor * 4;
    alu_imm(5'd12, 5'd0, rv32i_pkg::ADDI, pc + 7);
    emit(i_type(rv32i_pkg::JALR, 5'd13, 3'b000, 5'd12, 12'd6));
    expect_write(5'd13, pc + 8);
    skip_slot();
    emit(rv32i_pkg::HALT_INSTR);
    apply_reset();
    run_until_halt();
  endtask

  task automatic test_auipc_x0();
    logic [31:0] r;
    int          pc;
    clear_program();
    alu_imm(5'd1, 5'd0, rv32i_pkg::ADDI, 12'd5);
    r = next_rand();
    pc = cursor * 4;
    emit(u_type(rv32i_pkg::AUIPC, 5'd14, r[31:12]));
    expect_write(5'd14, pc + {r[31:12], 12'd0});
    alu_imm(5'd0, 5'd1, rv32i_pkg::ADDI, 12'h123);
    emit(u_type(rv32i_pkg::LUI, 5'd0, r[19:0]));
    alu_reg(5'd15, 5'd0, 5'd0, rv32i_pkg::ADDSUB, 1'b0);
    alu_imm(5'd16, 5'd0, rv32i_pkg::ADDI, 12'd7);
    emit(rv32i_pkg::HALT_INSTR);
    apply_reset();
    run_until_halt();
  endtask

  task automatic test_halt_run();
    logic [31:0] halt_pc;
    clear_program();
    emit(s_type(rv32i_pkg::LW, 5'd0, 5'd0, 12'h40));
    expect_store(32'h40, 4'b1111, 32'd0);
    alu_imm(5'd1, 5'd0, rv32i_pkg::ADDI, 12'd1);
    halt_pc = cursor * 4;
    emit(rv32i_pkg::HALT_INSTR);
    // Words past the halt that must never run
    imem[cursor] = i_type(rv32i_pkg::IMMED, 5'd2, rv32i_pkg::ADDI, 5'd0, 12'd2);
    imem[cursor + 1] = s_type(rv32i_pkg::LW, 5'd0, 5'd0, 12'h44);
    apply_reset();
    check_frozen(32'd0, 1'b0);
    run_until_halt();
    check_frozen(halt_pc, 1'b1);
  endtask

  initial begin
    clear_program();
    test_alu();
    test_load_store();
    test_control_flow();
    test_auipc_x0();
    test_halt_run();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
